// File: hdl/cdb_consts.svh
`ifndef CDB_CONSTS_SVH
`define CDB_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

// operand and result word
`define CDB_DATA_W 32

// operation tag, returned with the result
`define CDB_TAG_W 4

//////////////////////////////////////////////////////////////////////
// unit latencies, acceptance to broadcast
//////////////////////////////////////////////////////////////////////

`define ALU_LATENCY 1
`define MUL_LATENCY 3

`endif

// File: hdl/cdb_pkg.sv
`include "cdb_consts.svh"

package cdb_pkg;

	// data and tag words
	typedef logic [`CDB_DATA_W-1:0] word_t;
	typedef logic [`CDB_TAG_W-1:0]  tag_t;

	// operation codes
	// code 3 left free
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MUL = 2'd2
	} op_t;

	// one booked slot on the result bus
	typedef struct packed {
		logic valid;
		tag_t tag;
	} rsv_entry_t;

endpackage

// File: hdl/unit_issue_if.sv
`timescale 1ns/1ps

interface unit_issue_if;
	import cdb_pkg::*;

	// one issued operation, no stall path back
	logic  valid;
	logic  sub;
	word_t a;
	word_t b;

	// scheduler side
	modport scheduler (
		output valid,
		output sub,
		output a,
		output b
	);

	// execution unit side
	modport unit (
		input valid,
		input sub,
		input a,
		input b
	);

endinterface

// File: hdl/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
	parameter int  DEPTH     = 2,
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t in,
	output payload_t taps [DEPTH]
);

	// first stage loads the input
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			taps[0] <= '0;
		end else begin
			taps[0] <= in;
		end
	end

	// remaining stages shift one per cycle
	for (genvar i = 1; i < DEPTH; i++) begin : g_stage
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				taps[i] <= '0;
			end else begin
				taps[i] <= taps[i-1];
			end
		end
	end

endmodule

// File: hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
	input  logic           clk,
	input  logic           rst_n,
	unit_issue_if.unit     issue,
	output cdb_pkg::word_t result
);
	import cdb_pkg::*;

	word_t sum;
	word_t diff;

	//////////////////////////////////////////////////////////////////////
	// arithmetic
	//////////////////////////////////////////////////////////////////////

	// both results formed, sub picks one
	assign sum  = issue.a + issue.b;
	assign diff = issue.a - issue.b;

	//////////////////////////////////////////////////////////////////////
	// result stage
	//////////////////////////////////////////////////////////////////////

	// holds its value between issues
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
		end else if (issue.valid) begin
			if (issue.sub) begin
				result <= diff;
			end else begin
				result <= sum;
			end
		end
	end

endmodule

// File: hdl/mul_unit.sv
`timescale 1ns/1ps
`include "cdb_consts.svh"

module mul_unit (
	input  logic           clk,
	input  logic           rst_n,
	unit_issue_if.unit     issue,
	output cdb_pkg::word_t result
);
	import cdb_pkg::*;

	logic [2*`CDB_DATA_W-1:0] full_product;
	word_t                    product;
	word_t                    prod_taps [`MUL_LATENCY-1];

	//////////////////////////////////////////////////////////////////////
	// first stage
	//////////////////////////////////////////////////////////////////////

	assign full_product = issue.a * issue.b;

	// only the low half goes on the bus
	always_ff @(posedge clk) begin
		if (issue.valid) begin
			product <= full_product[`CDB_DATA_W-1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// remaining stages
	//////////////////////////////////////////////////////////////////////

	// shifts every cycle, so a new multiply can enter each cycle
	delay_line #(
		.DEPTH     (`MUL_LATENCY - 1),
		.payload_t (word_t)
	) u_prod_delay (
		.clk   (clk),
		.rst_n (rst_n),
		.in    (product),
		.taps  (prod_taps)
	);

	// last tap lines up with the booked bus slot
	assign result = prod_taps[`MUL_LATENCY-2];

endmodule

// File: hdl/cdb_scheduler.sv
`timescale 1ns/1ps
`include "cdb_consts.svh"

module cdb_scheduler (
	input  logic            clk,
	input  logic            rst_n,
	// issue side
	input  logic            issue_valid,
	output logic            issue_ready,
	input  cdb_pkg::op_t    issue_op,
	input  cdb_pkg::tag_t   issue_tag,
	input  cdb_pkg::word_t  issue_a,
	input  cdb_pkg::word_t  issue_b,
	// execution units
	unit_issue_if.scheduler alu_issue,
	unit_issue_if.scheduler mul_issue,
	input  cdb_pkg::word_t  alu_result,
	input  cdb_pkg::word_t  mul_result,
	// result bus
	output logic            cdb_valid,
	output cdb_pkg::tag_t   cdb_tag,
	output cdb_pkg::word_t  cdb_data
);
	import cdb_pkg::*;

	// multiply booking that owns the bus this cycle
	localparam int LAST_TAP    = `MUL_LATENCY - 1;
	// multiply booking that an add accepted now would land on
	localparam int COLLIDE_TAP = `MUL_LATENCY - `ALU_LATENCY - 1;

	logic       is_mul;
	logic       accept;
	logic       accept_alu;
	logic       accept_mul;
	logic       mul_owns_bus;
	rsv_entry_t mul_rsv_in;
	rsv_entry_t mul_rsv [`MUL_LATENCY];
	rsv_entry_t alu_rsv;

	//////////////////////////////////////////////////////////////////////
	// issue handshake
	//////////////////////////////////////////////////////////////////////

	assign is_mul = (issue_op == OP_MUL);

	// multiply always goes, it books the slot ahead
	// short op refused when its slot is already taken
	assign issue_ready = is_mul || !mul_rsv[COLLIDE_TAP].valid;

	assign accept     = issue_valid && issue_ready;
	assign accept_alu = accept && !is_mul;
	assign accept_mul = accept && is_mul;

	//////////////////////////////////////////////////////////////////////
	// routing to units
	//////////////////////////////////////////////////////////////////////

	assign alu_issue.valid = accept_alu;
	assign alu_issue.sub   = (issue_op == OP_SUB);
	assign alu_issue.a     = issue_a;
	assign alu_issue.b     = issue_b;

	// mul unit has no use for sub
	assign mul_issue.valid = accept_mul;
	assign mul_issue.sub   = 1'b0;
	assign mul_issue.a     = issue_a;
	assign mul_issue.b     = issue_b;

	//////////////////////////////////////////////////////////////////////
	// reservation chain
	//////////////////////////////////////////////////////////////////////

	assign mul_rsv_in.valid = accept_mul;
	assign mul_rsv_in.tag   = issue_tag;

	// multiply bookings, one stage per cycle
	delay_line #(
		.DEPTH     (`MUL_LATENCY),
		.payload_t (rsv_entry_t)
	) u_mul_rsv (
		.clk   (clk),
		.rst_n (rst_n),
		.in    (mul_rsv_in),
		.taps  (mul_rsv)
	);

	// add/sub booking, lives for the single cycle of its result
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alu_rsv <= '0;
		end else begin
			alu_rsv.valid <= accept_alu;
			alu_rsv.tag   <= issue_tag;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// result bus
	//////////////////////////////////////////////////////////////////////

	assign mul_owns_bus = mul_rsv[LAST_TAP].valid;

	// never both valid, the ready rule keeps them apart
	assign cdb_valid = mul_owns_bus || alu_rsv.valid;
	assign cdb_tag   = mul_owns_bus ? mul_rsv[LAST_TAP].tag : alu_rsv.tag;
	assign cdb_data  = mul_owns_bus ? mul_result : alu_result;

endmodule

// File: hdl/cdb_core.sv
`timescale 1ns/1ps

module cdb_core (
	input  logic           clk,
	input  logic           rst_n,
	// issue
	input  logic           issue_valid,
	output logic           issue_ready,
	input  cdb_pkg::op_t   issue_op,
	input  cdb_pkg::tag_t  issue_tag,
	input  cdb_pkg::word_t issue_a,
	input  cdb_pkg::word_t issue_b,
	// result bus
	output logic           cdb_valid,
	output cdb_pkg::tag_t  cdb_tag,
	output cdb_pkg::word_t cdb_data
);
	import cdb_pkg::*;

	word_t alu_result;
	word_t mul_result;

	// one issue path per unit
	unit_issue_if alu_if();
	unit_issue_if mul_if();

	//////////////////////////////////////////////////////////////////////
	// bus scheduler
	//////////////////////////////////////////////////////////////////////

	cdb_scheduler u_scheduler (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_op    (issue_op),
		.issue_tag   (issue_tag),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.alu_issue   (alu_if),
		.mul_issue   (mul_if),
		.alu_result  (alu_result),
		.mul_result  (mul_result),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_data    (cdb_data)
	);

	//////////////////////////////////////////////////////////////////////
	// execution units
	//////////////////////////////////////////////////////////////////////

	alu_unit u_alu (
		.clk    (clk),
		.rst_n  (rst_n),
		.issue  (alu_if),
		.result (alu_result)
	);

	mul_unit u_mul (
		.clk    (clk),
		.rst_n  (rst_n),
		.issue  (mul_if),
		.result (mul_result)
	);

endmodule

// File: testbench/tb_cdb_core.sv
`timescale 1ns/1ps
`include "cdb_consts.svh"

module tb_cdb_core;
	import cdb_pkg::*;

	logic   clk;
	logic   rst_n;
	logic   issue_valid;
	logic   issue_ready;
	op_t    issue_op;
	tag_t   issue_tag;
	word_t  issue_a;
	word_t  issue_b;
	logic   cdb_valid;
	tag_t   cdb_tag;
	word_t  cdb_data;

	// vectors from the input file
	op_t    v_op [64];
	word_t  v_a [64];
	word_t  v_b [64];
	tag_t   v_tag [64];
	int     v_gap [64];
	int     n_vec = 0;
	int     max_gap = 0;
	logic   loaded = 1'b0;
	logic   load_ok;
	int     wd_cycles;
	integer seed = 32'h3ed5b29c;

	// expected bus traffic, keyed by cycle
	word_t  exp_data [int];
	tag_t   exp_tag [int];
	int     exp_test [int];
	int     tag_seen [16];
	int     test_err [6];
	int     n_checks = 0;
	int     errors = 0;
	int     cyc = 0;
	logic   [1:0] mul_hist = 2'b00;
	logic   ready_model;
	logic   hs_mul;
	int     mul_run = 0;
	int     refused = 0;
	logic   overlap_seen = 1'b0;

	cdb_core u_dut (.*);

	always #5 clk = ~clk;

	always @(posedge clk) cyc = cyc + 1;

	task automatic check(input int test_id, input word_t got, input word_t exp,
			input string msg);
		n_checks++;
		if (got !== exp) begin
			errors++;
			test_err[test_id]++;
			$display("FAIL %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	function automatic word_t model_result(input op_t op, input word_t a, input word_t b);
		case (op)
			OP_SUB:  return a - b;
			OP_MUL:  return a * b;
			default: return a + b;
		endcase
	endfunction

	function automatic string test_name(input int k);
		case (k)
			0:       return "reset";
			1:       return "add/sub";
			2:       return "multiply";
			3:       return "overlap";
			4:       return "collision";
			default: return "bus integrity";
		endcase
	endfunction

	task automatic report_test(input int k);
		$display("test %0d %s: %s", k, test_name(k), (test_err[k] == 0) ? "ok" : "FAILED");
	endtask

	// result due L cycles after the handshake cycle
	task automatic book_result(input int c);
		int due;
		due = c + ((issue_op == OP_MUL) ? `MUL_LATENCY : `ALU_LATENCY);
		exp_data[due] = model_result(issue_op, issue_a, issue_b);
		exp_tag[due]  = issue_tag;
		exp_test[due] = (issue_op == OP_MUL) ? 2 : 1;
	endtask

	////////////////////////////////////////////////////////////////////
	// monitor and reference model
	////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (rst_n) begin
			if (exp_tag.exists(cyc)) begin
				check(exp_test[cyc], cdb_valid, 1'b1, "result valid");
				check(exp_test[cyc], cdb_tag, exp_tag[cyc], "result tag");
				check(exp_test[cyc], cdb_data, exp_data[cyc], "result data");
				// run of multiply results seen on the bus
				if (exp_test[cyc] == 2 && cdb_valid === 1'b1 && cdb_tag === exp_tag[cyc]) begin
					mul_run++;
				end else begin
					mul_run = 0;
				end
				if (mul_run >= 3) begin
					overlap_seen = 1'b1;
				end
				exp_tag.delete(cyc);
				exp_data.delete(cyc);
				exp_test.delete(cyc);
			end else begin
				check(5, cdb_valid, 1'b0, "bus idle");
				mul_run = 0;
			end
			if (cdb_valid) begin
				tag_seen[cdb_tag]++;
			end
			// short op refused when a multiply went two cycles ago
			ready_model = (issue_op == OP_MUL) || !mul_hist[1];
			check(4, issue_ready, ready_model, "issue_ready");
			if (issue_valid && !issue_ready) begin
				refused++;
			end
			if (issue_valid && ready_model) begin
				book_result(cyc);
			end
			hs_mul = issue_valid && ready_model && (issue_op == OP_MUL);
			mul_hist = {mul_hist[0], hs_mul};
		end
	end

	task automatic load_vectors(output logic ok);
		int    fd;
		int    r;
		int    f_op;
		int    f_gap;
		word_t f_a;
		word_t f_b;
		tag_t  f_tag;
		string line;
		ok = 1'b0;
		fd = $fopen("testbench/cdb_input.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				r = $fgets(line, fd);
				if (r > 1 && line.getc(0) != "#") begin
					r = $sscanf(line, "%d %h %h %h %d", f_op, f_a, f_b, f_tag, f_gap);
					if (r == 5 && n_vec < 64) begin
						v_op[n_vec]  = op_t'(f_op);
						v_a[n_vec]   = f_a;
						v_b[n_vec]   = f_b;
						v_tag[n_vec] = f_tag;
						v_gap[n_vec] = f_gap;
						if (f_gap > max_gap) begin
							max_gap = f_gap;
						end
						n_vec++;
					end
				end
			end
			$fclose(fd);
			ok = (n_vec > 0);
		end
	endtask

	task automatic reset_test();
		for (int k = 0; k < 3; k++) begin
			issue_op = op_t'(k);
			@(negedge clk);
			check(0, issue_ready, 1'b1, "issue_ready after reset");
			check(0, cdb_valid, 1'b0, "cdb_valid after reset");
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_vectors();
		int extra;
		for (int i = 0; i < n_vec; i++) begin
			issue_valid = 1'b1;
			issue_op    = v_op[i];
			issue_a     = v_a[i];
			issue_b     = v_b[i];
			issue_tag   = v_tag[i];
			// held until a sampled cycle shows ready
			@(negedge clk);
			while (!issue_ready) begin
				@(negedge clk);
			end
			@(posedge clk);
			#1;
			// gap 0 keeps vectors back to back
			if (v_gap[i] > 0) begin
				issue_valid = 1'b0;
				extra = {$random(seed)} % 3;
				repeat (v_gap[i] + extra) @(posedge clk);
				#1;
			end
		end
		issue_valid = 1'b0;
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue_op    = OP_ADD;
		issue_tag   = '0;
		issue_a     = '0;
		issue_b     = '0;
		load_vectors(load_ok);
		if (!load_ok) begin
			$display("no vectors could be read from testbench/cdb_input.txt");
			$display("sim failed");
			$finish;
		end else begin
			wd_cycles = n_vec * (max_gap + 6) + 20;
			loaded = 1'b1;
			repeat (3) @(posedge clk);
			#1;
			rst_n = 1'b1;
			reset_test();
			report_test(0);
			run_vectors();
			while (exp_tag.num() != 0) @(posedge clk);
			repeat (4) @(posedge clk);
			check(3, overlap_seen, 1'b1, "three multiplies back to back");
			check(4, refused > 0, 1'b1, "add refused behind a multiply");
			for (int i = 0; i < n_vec; i++) begin
				if (tag_seen[v_tag[i]] != 1) begin
					$display("tag %h was seen %0d times on the bus instead of once",
						v_tag[i], tag_seen[v_tag[i]]);
					errors++;
					test_err[5]++;
				end
			end
			for (int k = 1; k < 6; k++) begin
				report_test(k);
			end
			$display("checks %0d, errors %0d", n_checks, errors);
			if (errors == 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
			$finish;
		end
	end

	// watchdog
	initial begin
		wait (loaded);
		#(wd_cycles * 10);
		$display("watchdog expired, the run did not finish within %0d cycles", wd_cycles);
		$display("sim failed");
		$finish;
	end

endmodule

// File: testbench/cdb_input.txt
# op (0 add, 1 sub, 2 mul), operand a (hex), operand b (hex), tag (hex), idle gap (cycles)
# gap 0 presents the next vector in the cycle after acceptance
0 00000005 00000007 0 1
1 00000003 0000000a 1 2
0 ffffffff 00000002 2 0
2 00000006 00000007 3 2
2 00010003 00010005 4 1
2 00000002 00000003 5 0
2 00000004 00000005 6 0
2 ffffffff ffffffff 7 3
2 00000011 00000003 8 0
0 00000100 00000001 9 0
1 00000050 00000020 a 2
1 80000000 00000001 b 0
2 fffffffe 00000003 c 1
0 7fffffff 00000001 d 0
2 12345678 00000010 e 0
0 00000001 00000001 f 4

// File: list.f
+incdir+hdl
hdl/cdb_pkg.sv
hdl/unit_issue_if.sv
hdl/delay_line.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/cdb_scheduler.sv
hdl/cdb_core.sv
testbench/tb_cdb_core.sv

// File: Bender.yml
package:
  name: cdb_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cdb_pkg.sv
      - hdl/unit_issue_if.sv
      - hdl/delay_line.sv
      - hdl/alu_unit.sv
      - hdl/mul_unit.sv
      - hdl/cdb_scheduler.sv
      - hdl/cdb_core.sv
      - target: simulation
        files:
          - testbench/tb_cdb_core.sv
